// ==== Bender.yml ====
package:
  name: dma_subsys

sources:
  - source/mem_bus_pkg.sv
  - source/dma_cfg_pkg.sv
  - source/dma_frontend.sv
  - source/dma_backend.sv
  - source/mem_arbiter.sv
  - source/scratch_mem.sv
  - source/dma_subsys_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_dma_subsys.sv

// ==== files.f ====
+incdir+sim
source/mem_bus_pkg.sv
source/dma_cfg_pkg.sv
source/dma_frontend.sv
source/dma_backend.sv
source/mem_arbiter.sv
source/scratch_mem.sv
source/dma_subsys_top.sv
sim/tb_dma_subsys.sv

// ==== sim/tb_dma_model.svh ====
// testbench helpers included into the DMA testbench module
// LFSR random bits, value check, register and memory bus tasks with timeouts
// reference model of the scratch memory and its word copy

`ifndef TB_DMA_MODEL_SVH
`define TB_DMA_MODEL_SVH

localparam logic [15:0] LfsrSeed   = 16'd65;
// cycles allowed for one ack edge
localparam int unsigned AckTimeout = 50;
// status reads allowed while waiting for done
localparam int unsigned PollLimit  = 400;

logic [15:0] lfsr;
logic [31:0] model_mem [MemWords];

// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
function automatic logic [31:0] rand_bits(input int unsigned width);
  logic [31:0] value;
  logic        fb;
  value = '0;
  for (int unsigned i = 0; i < width; i++) begin
    fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr  = {lfsr[14:0], fb};
    value = {value[30:0], fb};
  end
  return value;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    $display("ERROR at %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
    error_count++;
  end
endtask

// wait on the register bus or host memory port for ack to reach a level
task automatic wait_ack(input bit mem_port, input logic level, input string what);
  int unsigned cycles;
  cycles = 0;
  while (((mem_port ? host_mem_rsp.ack : cfg_rsp.ack) !== level) && cycles < AckTimeout) begin
    @(negedge clk);
    cycles++;
  end
  if ((mem_port ? host_mem_rsp.ack : cfg_rsp.ack) !== level) begin
    $display("%s: ack did not %s within %0d cycles", what, level ? "rise" : "fall", AckTimeout);
    error_count++;
  end
endtask

task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
  @(negedge clk);
  cfg_req.req   = 1'b1;
  cfg_req.we    = 1'b1;
  cfg_req.addr  = addr;
  cfg_req.wdata = data;
  wait_ack(1'b0, 1'b1, "register write");
  cfg_req.req = 1'b0;
  wait_ack(1'b0, 1'b0, "register write");
endtask

task automatic cfg_read(input logic [1:0] addr, output logic [31:0] data);
  @(negedge clk);
  cfg_req.req  = 1'b1;
  cfg_req.we   = 1'b0;
  cfg_req.addr = addr;
  wait_ack(1'b0, 1'b1, "register read");
  // read data valid while ack is high
  data        = cfg_rsp.rdata;
  cfg_req.req = 1'b0;
  wait_ack(1'b0, 1'b0, "register read");
endtask

task automatic mem_write(input logic [15:0] addr, input logic [31:0] data);
  @(negedge clk);
  host_mem_req.req   = 1'b1;
  host_mem_req.we    = 1'b1;
  host_mem_req.addr  = addr;
  host_mem_req.wdata = data;
  wait_ack(1'b1, 1'b1, "host memory write");
  host_mem_req.req = 1'b0;
  wait_ack(1'b1, 1'b0, "host memory write");
endtask

task automatic mem_read(input logic [15:0] addr, output logic [31:0] data);
  @(negedge clk);
  host_mem_req.req  = 1'b1;
  host_mem_req.we   = 1'b0;
  host_mem_req.addr = addr;
  wait_ack(1'b1, 1'b1, "host memory read");
  data             = host_mem_rsp.rdata;
  host_mem_req.req = 1'b0;
  wait_ack(1'b1, 1'b0, "host memory read");
endtask

// sequential ascending copy, addresses wrap modulo the memory size
function automatic void model_copy(input int unsigned src, input int unsigned dst,
                                   input int unsigned len);
  for (int unsigned i = 0; i < len; i++) begin
    model_mem[(dst + i) % MemWords] = model_mem[(src + i) % MemWords];
  end
endfunction

`endif

// ==== sim/tb_dma_subsys.sv ====
// testbench of the DMA subsystem
// clock, reset, DUT instance and the numbered tests

`default_nettype none

module tb_dma_subsys;

  import mem_bus_pkg::*;
  import dma_cfg_pkg::*;

  localparam int unsigned MemWords = 256;

  logic     clk;
  logic     arst_n;
  cfg_req_t cfg_req;
  cfg_rsp_t cfg_rsp;
  mem_req_t host_mem_req;
  mem_rsp_t host_mem_rsp;

  int unsigned error_count;
  int unsigned errors_before;
  int unsigned tests_run;
  int unsigned tests_failed;

  `include "tb_dma_model.svh"

  dma_subsys_top #(
    .MemDepth (MemWords)
  ) dma_subsys_top_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .cfg_req_i      (cfg_req),
    .cfg_rsp_o      (cfg_rsp),
    .host_mem_req_i (host_mem_req),
    .host_mem_rsp_o (host_mem_rsp)
  );

  // 40 time unit period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_test(input int unsigned num, input string name);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", num, name);
    end
    errors_before = error_count;
  endtask

  // program the three registers and then write the launch register
  task automatic launch_copy(input int unsigned src, input int unsigned dst,
                             input int unsigned len);
    cfg_write(RegSrc, 32'(src));
    cfg_write(RegDst, 32'(dst));
    cfg_write(RegLen, 32'(len));
    cfg_write(RegCtrl, 32'h1);
  endtask

  // poll status until done and expect busy clear with done set
  task automatic wait_dma_done();
    logic [31:0] status;
    int unsigned polls;
    status = '0;
    polls  = 0;
    while (!status[StatusDoneBit] && polls < PollLimit) begin
      cfg_read(RegCtrl, status);
      polls++;
    end
    if (!status[StatusDoneBit]) begin
      $display("DMA copy did not report done within %0d status polls", PollLimit);
      error_count++;
    end else begin
      check_value("status after copy", 32'h2, status);
    end
  endtask

  // read the whole memory through the host port
  task automatic compare_memory();
    logic [31:0] data;
    for (int unsigned a = 0; a < MemWords; a++) begin
      mem_read(16'(a), data);
      check_value($sformatf("mem[%0d]", a), model_mem[a], data);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] wr_val [3];
    int unsigned src;
    int unsigned dst;
    int unsigned len;
    cfg_req       = '0;
    host_mem_req  = '0;
    arst_n        = 1'b0;
    lfsr          = LfsrSeed;
    error_count   = 0;
    errors_before = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    // everything cleared by reset
    cfg_read(RegCtrl, rd);
    check_value("status", 32'h0, rd);
    cfg_read(RegSrc, rd);
    check_value("src register", 32'h0, rd);
    cfg_read(RegDst, rd);
    check_value("dst register", 32'h0, rd);
    cfg_read(RegLen, rd);
    check_value("len register", 32'h0, rd);
    report_test(1, "reset state");

    // indices 0 to 2 hold src, dst and len of 16 bits each
    for (int unsigned r = 0; r < 3; r++) begin
      wr_val[r] = rand_bits(16);
      cfg_write(2'(r), wr_val[r]);
    end
    for (int unsigned r = 0; r < 3; r++) begin
      cfg_read(2'(r), rd);
      check_value($sformatf("register %0d", r), wr_val[r], rd);
    end
    report_test(2, "register readback");

    // random fill through the host port while done is still clear from reset
    for (int unsigned a = 0; a < MemWords; a++) begin
      model_mem[a] = rand_bits(32);
      mem_write(16'(a), model_mem[a]);
    end
    // an empty launch sets done at once and moves no data
    cfg_write(RegLen, 32'h0);
    cfg_write(RegCtrl, 32'h1);
    cfg_read(RegCtrl, rd);
    check_value("status after empty launch", 32'h2, rd);
    compare_memory();
    report_test(3, "zero length");

    // copies from the low quarter into the third quarter
    repeat (4) begin
      len = rand_bits(4) + 1;
      src = rand_bits(6);
      dst = 128 + rand_bits(6);
      launch_copy(src, dst, len);
      wait_dma_done();
      model_copy(src, dst, len);
    end
    compare_memory();
    report_test(4, "copy");

    // the second launch lands while 16 words are still in flight
    launch_copy(16, 144, 16);
    launch_copy(32, 208, 8);
    cfg_read(RegCtrl, rd);
    check_value("status during copy", 32'h1, rd);
    wait_dma_done();
    model_copy(16, 144, 16);
    compare_memory();
    report_test(5, "launch while busy");

    // host traffic in the top quarter away from both copy regions
    src = rand_bits(6);
    dst = 128 + rand_bits(6);
    launch_copy(src, dst, 16);
    for (int unsigned i = 0; i < 8; i++) begin
      model_mem[224 + i] = rand_bits(32);
      mem_write(16'(224 + i), model_mem[224 + i]);
    end
    for (int unsigned i = 0; i < 8; i++) begin
      mem_read(16'(224 + i), rd);
      check_value($sformatf("host read mem[%0d]", 224 + i), model_mem[224 + i], rd);
    end
    wait_dma_done();
    model_copy(src, dst, 16);
    compare_memory();
    report_test(6, "contention");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_dma_subsys

`default_nettype wire

// ==== source/dma_backend.sv ====
// word-by-word copy engine of the DMA
// one read then one write per word, ascending, on a single memory port
// burst acked and done pulsed once the last write has closed

`default_nettype none

module dma_backend (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    burst_req_i,
  input  wire dma_cfg_pkg::burst_req_t burst_i,
  output      logic                    burst_ack_o,
  output      logic                    done_o,
  output      mem_bus_pkg::mem_req_t   mem_req_o,
  input  wire mem_bus_pkg::mem_rsp_t   mem_rsp_i
);

  import mem_bus_pkg::*;
  import dma_cfg_pkg::*;

  typedef enum logic [2:0] {
    StIdle,
    StRead,
    StReadRel,
    StWrite,
    StWriteRel,
    StFinish
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic [AddrWidth-1:0] idx_q;
  logic [AddrWidth-1:0] idx_d;
  logic                 done_q;
  logic                 done_d;
  logic                 last_word;

  // latched burst and the word in flight
  burst_req_t           burst_q;
  logic [DataWidth-1:0] data_q;

  assign last_word = (idx_q == burst_q.num_words - AddrWidth'(1));

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    done_d  = 1'b0;
    case (state_q)
      StIdle: begin
        if (burst_req_i) begin
          idx_d = '0;
          // empty burst goes straight to the ack
          if (burst_i.num_words == '0) begin
            state_d = StFinish;
            done_d  = 1'b1;
          end else begin
            state_d = StRead;
          end
        end
      end
      // read phase, data captured with ack
      StRead: begin
        if (mem_rsp_i.ack) begin
          state_d = StReadRel;
        end
      end
      StReadRel: begin
        if (!mem_rsp_i.ack) begin
          state_d = StWrite;
        end
      end
      StWrite: begin
        if (mem_rsp_i.ack) begin
          state_d = StWriteRel;
        end
      end
      // write closed, next word or finish
      StWriteRel: begin
        if (!mem_rsp_i.ack) begin
          if (last_word) begin
            state_d = StFinish;
            done_d  = 1'b1;
          end else begin
            idx_d   = idx_q + AddrWidth'(1);
            state_d = StRead;
          end
        end
      end
      // ack held until the frontend drops its request
      StFinish: begin
        if (!burst_req_i) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= StIdle;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && burst_req_i) begin
      burst_q <= burst_i;
    end
    if (state_q == StRead && mem_rsp_i.ack) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

  // memory port driven from state, payload stable while req is high
  always_comb begin
    mem_req_o = '0;
    case (state_q)
      StRead: begin
        mem_req_o.req  = 1'b1;
        mem_req_o.addr = burst_q.src + idx_q;
      end
      StWrite: begin
        mem_req_o.req   = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = burst_q.dst + idx_q;
        mem_req_o.wdata = data_q;
      end
      default: mem_req_o = '0;
    endcase
  end

  assign burst_ack_o = (state_q == StFinish);
  assign done_o      = done_q;

endmodule : dma_backend

`default_nettype wire

// ==== source/dma_cfg_pkg.sv ====
// register map of the DMA frontend and its status bits
// register bus request and response structs
// burst request handed from frontend to backend

`default_nettype none

package dma_cfg_pkg;

  // four registers, so a 2-bit word index
  localparam int unsigned RegIdxWidth = 2;

  localparam logic [RegIdxWidth-1:0] RegSrc  = 2'd0;
  localparam logic [RegIdxWidth-1:0] RegDst  = 2'd1;
  // length counted in words
  localparam logic [RegIdxWidth-1:0] RegLen  = 2'd2;
  // write launches, read returns status
  localparam logic [RegIdxWidth-1:0] RegCtrl = 2'd3;

  // status bit positions in a RegCtrl read
  localparam int unsigned StatusBusyBit = 0;
  localparam int unsigned StatusDoneBit = 1;

  typedef struct packed {
    logic                                 req;
    logic                                 we;
    logic [RegIdxWidth-1:0]               addr;
    logic [mem_bus_pkg::DataWidth-1:0]    wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                                 ack;
    logic [mem_bus_pkg::DataWidth-1:0]    rdata;
  } cfg_rsp_t;

  // one linear word copy, num_words read as unsigned
  typedef struct packed {
    logic [mem_bus_pkg::AddrWidth-1:0] src;
    logic [mem_bus_pkg::AddrWidth-1:0] dst;
    logic [mem_bus_pkg::AddrWidth-1:0] num_words;
  } burst_req_t;

endpackage : dma_cfg_pkg

`default_nettype wire

// ==== source/dma_frontend.sv ====
// register-programmed DMA frontend
// source, destination and length registers, launch decode
// busy and sticky done status, burst request handshake to the backend

`default_nettype none

module dma_frontend (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire dma_cfg_pkg::cfg_req_t   cfg_req_i,
  output      dma_cfg_pkg::cfg_rsp_t   cfg_rsp_o,
  output      logic                    burst_req_o,
  output      dma_cfg_pkg::burst_req_t burst_o,
  input  wire logic                    burst_ack_i,
  input  wire logic                    backend_done_i
);

  import mem_bus_pkg::*;
  import dma_cfg_pkg::*;

  // register bus handshake
  logic                 ack_q;
  logic [DataWidth-1:0] rdata_q;
  logic [DataWidth-1:0] rd_val;
  logic                 access;
  logic                 launch;
  logic                 launch_ok;

  // configuration, only the word address bits are kept
  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  logic [AddrWidth-1:0] len_q;

  // status and burst channel
  logic                 busy_q;
  logic                 done_q;
  logic                 burst_req_q;
  burst_req_t           burst_q;

  // a new request is served on the edge where ack rises
  assign access = cfg_req_i.req && !ack_q;
  assign launch = access && cfg_req_i.we && (cfg_req_i.addr == RegCtrl);
  // a burst handshake still closing counts as busy too
  assign launch_ok = !busy_q && !burst_req_q && !burst_ack_i;

  // read mux, registers are zero-extended to the bus width
  always_comb begin
    rd_val = '0;
    case (cfg_req_i.addr)
      RegSrc:  rd_val = DataWidth'(src_q);
      RegDst:  rd_val = DataWidth'(dst_q);
      RegLen:  rd_val = DataWidth'(len_q);
      RegCtrl: begin
        rd_val[StatusBusyBit] = busy_q;
        rd_val[StatusDoneBit] = done_q;
      end
      default: rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q       <= 1'b0;
      src_q       <= '0;
      dst_q       <= '0;
      len_q       <= '0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      burst_req_q <= 1'b0;
    end else begin
      // four-phase ack follows req one edge later in both directions
      if (access) begin
        ack_q <= 1'b1;
      end else if (!cfg_req_i.req && ack_q) begin
        ack_q <= 1'b0;
      end
      if (access && cfg_req_i.we) begin
        case (cfg_req_i.addr)
          RegSrc:  src_q <= cfg_req_i.wdata[AddrWidth-1:0];
          RegDst:  dst_q <= cfg_req_i.wdata[AddrWidth-1:0];
          RegLen:  len_q <= cfg_req_i.wdata[AddrWidth-1:0];
          default: ;
        endcase
      end
      // launch while busy is dropped, zero length finishes at once
      if (launch && launch_ok) begin
        if (len_q == '0) begin
          done_q <= 1'b1;
        end else begin
          done_q      <= 1'b0;
          busy_q      <= 1'b1;
          burst_req_q <= 1'b1;
        end
      end
      // backend has latched the burst, release the request
      if (burst_ack_i) begin
        burst_req_q <= 1'b0;
      end
      // completion pulse ends busy and sets the sticky done flag
      if (backend_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // read data and burst payload, captured when they become valid
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rd_val;
    end
    if (launch && launch_ok) begin
      burst_q.src       <= src_q;
      burst_q.dst       <= dst_q;
      burst_q.num_words <= len_q;
    end
  end

  assign cfg_rsp_o.ack   = ack_q;
  assign cfg_rsp_o.rdata = rdata_q;
  assign burst_req_o     = burst_req_q;
  assign burst_o         = burst_q;

endmodule : dma_frontend

`default_nettype wire

// ==== source/dma_subsys_top.sv ====
// DMA subsystem top level
// frontend and backend, host and DMA ports arbitrated onto one scratch memory

`default_nettype none

module dma_subsys_top #(
  parameter int unsigned MemDepth = 256
) (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire dma_cfg_pkg::cfg_req_t cfg_req_i,
  output      dma_cfg_pkg::cfg_rsp_t cfg_rsp_o,
  input  wire mem_bus_pkg::mem_req_t host_mem_req_i,
  output      mem_bus_pkg::mem_rsp_t host_mem_rsp_o
);

  import mem_bus_pkg::*;
  import dma_cfg_pkg::*;

  // port 0 is the host, port 1 the DMA backend
  localparam int unsigned NumPorts = 2;

  logic       burst_req;
  logic       burst_ack;
  logic       backend_done;
  burst_req_t burst;

  mem_req_t                dma_mem_req;
  mem_rsp_t                dma_mem_rsp;
  mem_req_t [NumPorts-1:0] port_req;
  mem_rsp_t [NumPorts-1:0] port_rsp;
  mem_req_t                arb_mem_req;
  mem_rsp_t                arb_mem_rsp;

  assign port_req[0]    = host_mem_req_i;
  assign port_req[1]    = dma_mem_req;
  assign host_mem_rsp_o = port_rsp[0];
  assign dma_mem_rsp    = port_rsp[1];

  dma_frontend dma_frontend_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cfg_req_i      (cfg_req_i),
    .cfg_rsp_o      (cfg_rsp_o),
    .burst_req_o    (burst_req),
    .burst_o        (burst),
    .burst_ack_i    (burst_ack),
    .backend_done_i (backend_done)
  );

  dma_backend dma_backend_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .burst_req_i (burst_req),
    .burst_i     (burst),
    .burst_ack_o (burst_ack),
    .done_o      (backend_done),
    .mem_req_o   (dma_mem_req),
    .mem_rsp_i   (dma_mem_rsp)
  );

  mem_arbiter #(
    .NumPorts (NumPorts)
  ) mem_arbiter_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (port_req),
    .rsp_o     (port_rsp),
    .mem_req_o (arb_mem_req),
    .mem_rsp_i (arb_mem_rsp)
  );

  scratch_mem #(
    .MemDepth (MemDepth)
  ) scratch_mem_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (arb_mem_req),
    .rsp_o    (arb_mem_rsp)
  );

endmodule : dma_subsys_top

`default_nettype wire

// ==== source/mem_arbiter.sv ====
// round-robin arbiter sharing one memory port between several requesters
// grant locked across a full four-phase transaction

`default_nettype none

module mem_arbiter #(
  parameter int unsigned NumPorts = 2
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 arst_n_i,
  input  wire mem_bus_pkg::mem_req_t [NumPorts-1:0] req_i,
  output      mem_bus_pkg::mem_rsp_t [NumPorts-1:0] rsp_o,
  output      mem_bus_pkg::mem_req_t                mem_req_o,
  input  wire mem_bus_pkg::mem_rsp_t                mem_rsp_i
);

  localparam int unsigned IdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic                locked_q;
  logic [IdxWidth-1:0] grant_q;
  logic                release_now;
  logic                free;
  logic                pick_valid;
  logic [IdxWidth-1:0] pick_idx;
  logic [IdxWidth-1:0] sel;

  // transaction closed once both req and ack of the owner are low
  assign release_now = locked_q && !req_i[grant_q].req && !mem_rsp_i.ack;
  assign free        = !locked_q || release_now;

  // search starts after the last granted port, so it has lowest priority
  always_comb begin
    int unsigned cand;
    pick_valid = 1'b0;
    pick_idx   = grant_q;
    for (int unsigned k = 1; k <= NumPorts; k++) begin
      cand = (int'(grant_q) + k) % NumPorts;
      if (!pick_valid && req_i[cand].req) begin
        pick_valid = 1'b1;
        pick_idx   = IdxWidth'(cand);
      end
    end
  end

  assign sel = free ? pick_idx : grant_q;

  // forward the owner, a new owner already in the release cycle
  assign mem_req_o = (free && !pick_valid) ? '0 : req_i[sel];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
      grant_q  <= '0;
    end else if (free) begin
      locked_q <= pick_valid;
      if (pick_valid) begin
        grant_q <= pick_idx;
      end
    end
  end

  // waiting ports see ack low and zero data
  always_comb begin
    rsp_o = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      if (locked_q && grant_q == IdxWidth'(i)) begin
        rsp_o[i] = mem_rsp_i;
      end
    end
  end

endmodule : mem_arbiter

`default_nettype wire

// ==== source/mem_bus_pkg.sv ====
// memory bus widths shared by the whole subsystem
// memory request and response structs for the four-phase memory ports

`default_nettype none

package mem_bus_pkg;

  // word address width, every address in the subsystem is a word address
  localparam int unsigned AddrWidth = 16;
  // data word width
  localparam int unsigned DataWidth = 32;

  // requester side of a memory port
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  // responder side, rdata only valid while ack is high
  typedef struct packed {
    logic                 ack;
    logic [DataWidth-1:0] rdata;
  } mem_rsp_t;

endpackage : mem_bus_pkg

`default_nettype wire

// ==== source/scratch_mem.sv ====
// single-port scratch word memory with a four-phase port
// address wraps modulo the memory depth

`default_nettype none

module scratch_mem #(
  parameter int unsigned MemDepth = 256
) (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire mem_bus_pkg::mem_req_t req_i,
  output      mem_bus_pkg::mem_rsp_t rsp_o
);

  import mem_bus_pkg::*;

  localparam int unsigned IdxWidth = $clog2(MemDepth);

  logic [DataWidth-1:0] mem_q [MemDepth];
  logic [DataWidth-1:0] rdata_q;
  logic [IdxWidth-1:0]  idx;
  logic                 ack_q;
  logic                 access;

  // only the low address bits select a word
  assign idx    = req_i.addr[IdxWidth-1:0];
  assign access = req_i.req && !ack_q;

  // ack one edge after req, dropped one edge after req falls
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else if (access) begin
      ack_q <= 1'b1;
    end else if (!req_i.req && ack_q) begin
      ack_q <= 1'b0;
    end
  end

  // write and read both happen on the edge where ack rises
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (req_i.we) begin
        mem_q[idx] <= req_i.wdata;
      end
      rdata_q <= mem_q[idx];
    end
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.rdata = rdata_q;

endmodule : scratch_mem

`default_nettype wire
